//--- files.f
+incdir+sim
logic/tlb_pkg.sv
logic/tlb_way.sv
logic/tlb_victim_sel.sv
logic/tlb_update_seq.sv
logic/tlb_lookup.sv
logic/tlb_top.sv
sim/tb_tlb.sv

//--- Makefile
# Verilator flow for the TLB testbench
VERILATOR ?= verilator
TOP       ?= tb_tlb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the search for the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/tb_tlb_checks.svh
`ifndef TB_TLB_CHECKS_SVH
`define TB_TLB_CHECKS_SVH

int pass_count = 0;
int fail_count = 0;

task automatic report_failure(input string what);
  $display("ERROR at cycle %0d: %s", cycle_count, what);
  fail_count++;
endtask

// --------------------
// Value compares
// --------------------
task automatic compare_hit(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("MISMATCH %s at cycle %0d: expected 0x%h, got 0x%h",
             name, cycle_count, expected, actual);
    fail_count++;
  end else begin
    pass_count++;
  end
endtask

task automatic compare_entry(input string name, input tlb_entry_t expected,
                             input tlb_entry_t actual);
  if (actual !== expected) begin
    $display("MISMATCH %s at cycle %0d: expected 0x%h, got 0x%h",
             name, cycle_count, expected, actual);
    fail_count++;
  end else begin
    pass_count++;
  end
endtask

task automatic compare_ready(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("MISMATCH %s at cycle %0d: expected 0x%h, got 0x%h",
             name, cycle_count, expected, actual);
    fail_count++;
  end else begin
    pass_count++;
  end
endtask

`endif

//--- sim/tb_tlb.sv
`timescale 1ns/1ps

module tb_tlb import tlb_pkg::*; ();

  localparam int N_INSERTS   = 16;
  localparam int MIX_ROUNDS  = 40;
  localparam int MIX_UPDATES = 8;
  localparam int MIX_LOOKUPS = 64;
  // Roughly four times the cycles of all tests
  localparam int MAX_CYCLES  =
    4 * (MIX_ROUNDS * (MIX_UPDATES * 4 + MIX_LOOKUPS + 8) + 840);
  localparam tlb_idx_t FULL_SET = 6'h3c;

  logic         aclk;
  logic         aresetn;
  logic         upd_valid;
  tlb_upd_t     upd_cmd;
  logic         upd_ready;
  logic         lup_valid;
  tlb_lup_req_t lup_req;
  logic         rsp_valid;
  tlb_lup_rsp_t rsp;

  integer       seed;
  int           cycle_count = 0;
  int           test_checks;
  int           test_errors;

  // Model of the table contents and usage bits
  tlb_entry_t   m_entry [N_SETS][N_WAYS];
  logic         m_ref [N_SETS][N_WAYS];
  logic         m_mod [N_SETS][N_WAYS];
  way_t         last_victim;

  // Expected responses and the cycle each one is due
  tlb_lup_rsp_t exp_q [$];
  int           due_q [$];
  tlb_lup_rsp_t mon_rsp;
  int           mon_due;

  tlb_upd_t     ins_cmds [N_INSERTS];
  tlb_upd_t     set_cmds [5];
  tlb_upd_t     cmd;
  vaddr_t       va;
  tlb_idx_t     g_idx;
  tlb_tag_t     g_tag;
  pid_t         g_pid;
  int           g_way;

  `include "tb_tlb_checks.svh"

  tlb_top tlb_top_inst (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .upd_valid (upd_valid),
    .upd_cmd   (upd_cmd),
    .upd_ready (upd_ready),
    .lup_valid (lup_valid),
    .lup_req   (lup_req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  always #2 aclk = ~aclk;

  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // Responses are sampled mid-cycle
  always @(negedge aclk) begin
    if (rsp_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_failure("response seen with no lookup outstanding");
      end else begin
        mon_rsp = exp_q.pop_front();
        mon_due = due_q.pop_front();
        if (cycle_count != mon_due) begin
          report_failure($sformatf("response arrived %0d cycles off", cycle_count - mon_due));
        end
        compare_hit("rsp.hit", mon_rsp.hit, rsp.hit);
        compare_entry("rsp.entry", mon_rsp.entry, rsp.entry);
      end
    end
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Highest matching way, or -1
  function automatic int find_way(input tlb_idx_t idx, input tlb_tag_t tag, input pid_t pid);
    int found;
    found = -1;
    for (int w = 0; w < N_WAYS; w++) begin
      if (m_entry[idx][w].valid && m_entry[idx][w].tag == tag && m_entry[idx][w].pid == pid) begin
        found = w;
      end
    end
    return found;
  endfunction

  function automatic way_t pick_victim(input tlb_idx_t idx);
    way_t v;
    logic free;
    int   best;
    int   score;
    v    = '0;
    free = 1'b0;
    best = 4;
    for (int w = 0; w < N_WAYS; w++) begin
      if (!free && !m_entry[idx][w].valid) begin
        v    = way_t'(w);
        free = 1'b1;
      end
    end
    // Scanning downwards with a strict compare keeps the highest of equal scores
    if (!free) begin
      for (int w = N_WAYS - 1; w >= 0; w--) begin
        score = (m_ref[idx][w] ? 2 : 0) + (m_mod[idx][w] ? 1 : 0);
        if (score < best) begin
          best = score;
          v    = way_t'(w);
        end
      end
    end
    return v;
  endfunction

  task automatic apply_update(input tlb_upd_t c);
    way_t v;
    if (c.insert) begin
      v = pick_victim(c.vpn.idx);
      m_entry[c.vpn.idx][v].valid = 1'b1;
      m_entry[c.vpn.idx][v].pid   = c.pid;
      m_entry[c.vpn.idx][v].tag   = c.vpn.tag;
      m_entry[c.vpn.idx][v].ppn   = c.ppn;
      m_entry[c.vpn.idx][v].hpid  = c.hpid;
      m_ref[c.vpn.idx][v]         = 1'b0;
      m_mod[c.vpn.idx][v]         = 1'b0;
      last_victim                 = v;
    end else begin
      for (int w = 0; w < N_WAYS; w++) begin
        if (m_entry[c.vpn.idx][w].valid && m_entry[c.vpn.idx][w].tag == c.vpn.tag &&
            m_entry[c.vpn.idx][w].hpid == c.hpid) begin
          m_entry[c.vpn.idx][w].valid = 1'b0;
          m_ref[c.vpn.idx][w]         = 1'b0;
          m_mod[c.vpn.idx][w]         = 1'b0;
        end
      end
    end
  endtask

  task automatic predict_lookup(input vaddr_t vaddr, input pid_t pid, input logic wr,
                                output tlb_lup_rsp_t exp);
    tlb_idx_t idx;
    tlb_tag_t tag;
    int       w;
    idx = tlb_idx_t'(vaddr >> PG_BITS);
    tag = tlb_tag_t'(vaddr >> (PG_BITS + TLB_ORDER));
    w   = find_way(idx, tag, pid);
    exp = '0;
    if (w >= 0) begin
      exp.hit       = 1'b1;
      exp.entry     = m_entry[idx][w];
      m_ref[idx][w] = 1'b1;
      if (wr) begin
        m_mod[idx][w] = 1'b1;
      end
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic step_cycle();
    @(posedge aclk);
    #0.5;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) step_cycle();
  endtask

  task automatic build_cmd(input logic insert, input tlb_idx_t idx, input tlb_tag_t tag,
                           input pid_t pid, input hpid_t hpid, output tlb_upd_t c);
    c         = '0;
    c.insert  = insert;
    c.pid     = pid;
    c.vpn.idx = idx;
    c.vpn.tag = tag;
    c.ppn     = ppn_t'($random(seed));
    c.hpid    = hpid;
  endtask

  // Ready drops for READ and COMMIT, then returns
  task automatic send_update(input tlb_upd_t c);
    int waited;
    waited    = 0;
    upd_cmd   = c;
    upd_valid = 1'b1;
    while (upd_ready !== 1'b1 && waited < 16) begin
      step_cycle();
      waited++;
    end
    if (upd_ready !== 1'b1) begin
      report_failure("update port never became ready");
      upd_valid = 1'b0;
    end else begin
      apply_update(c);
      step_cycle();
      upd_valid = 1'b0;
      compare_ready("upd_ready", 1'b0, upd_ready);
      step_cycle();
      compare_ready("upd_ready", 1'b0, upd_ready);
      step_cycle();
      compare_ready("upd_ready", 1'b1, upd_ready);
    end
  endtask

  task automatic issue_lookup(input vaddr_t vaddr, input pid_t pid, input logic wr);
    tlb_lup_rsp_t exp;
    predict_lookup(vaddr, pid, wr, exp);
    exp_q.push_back(exp);
    due_q.push_back(cycle_count + 3);
    lup_valid     = 1'b1;
    lup_req.vaddr = vaddr;
    lup_req.pid   = pid;
    lup_req.wr    = wr;
    step_cycle();
  endtask

  task automatic lookup_mapping(input tlb_upd_t c, input pid_t pid, input logic wr);
    issue_lookup({c.vpn.tag, c.vpn.idx, 12'($random(seed))}, pid, wr);
  endtask

  task automatic end_lookups();
    int waited;
    waited    = 0;
    lup_valid = 1'b0;
    while (exp_q.size() != 0 && waited < 8) begin
      step_cycle();
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_failure("lookup responses did not arrive");
      exp_q.delete();
      due_q.delete();
    end
    idle_cycles(3);
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d, %s: %0d checks, %0d errors", num, name,
             pass_count + fail_count - test_checks, fail_count - test_errors);
    test_checks = pass_count + fail_count;
    test_errors = fail_count;
  endtask

  initial begin
    aclk        = 1'b0;
    aresetn     = 1'b0;
    upd_valid   = 1'b0;
    upd_cmd     = '0;
    lup_valid   = 1'b0;
    lup_req     = '0;
    seed        = 32'ha3fb2a37;
    test_checks = 0;
    test_errors = 0;
    for (int s = 0; s < N_SETS; s++) begin
      for (int w = 0; w < N_WAYS; w++) begin
        m_entry[s][w] = '0;
        m_ref[s][w]   = 1'b0;
        m_mod[s][w]   = 1'b0;
      end
    end
    repeat (2) @(posedge aclk);
    #0.5;
    aresetn = 1'b1;
    step_cycle();

    // Empty table after reset
    compare_ready("upd_ready", 1'b1, upd_ready);
    compare_hit("rsp_valid", 1'b0, rsp_valid);
    for (int i = 0; i < 24; i++) begin
      if (rand_below(2) == 1) begin
        issue_lookup(vaddr_t'({$random(seed), $random(seed)}), pid_t'($random(seed)),
                     1'($random(seed)));
      end else begin
        lup_valid = 1'b0;
        step_cycle();
      end
    end
    end_lookups();
    finish_test(1, "lookups after reset");

    for (int k = 0; k < N_INSERTS; k++) begin
      g_idx = tlb_idx_t'(rand_below(32));
      g_tag = tlb_tag_t'($random(seed));
      g_pid = pid_t'($random(seed));
      while (find_way(g_idx, g_tag, g_pid) >= 0) begin
        g_tag = g_tag + tlb_tag_t'(1);
      end
      build_cmd(1'b1, g_idx, g_tag, g_pid, hpid_t'($random(seed)), ins_cmds[k]);
      send_update(ins_cmds[k]);
    end
    idle_cycles(3);
    for (int k = 0; k < N_INSERTS; k++) begin
      lookup_mapping(ins_cmds[k], ins_cmds[k].pid, 1'($random(seed)));
      lookup_mapping(ins_cmds[k], ins_cmds[k].pid ^ 6'h01, 1'b0);
    end
    end_lookups();
    finish_test(2, "inserts then lookups");

    // Two matching removes, one with the wrong host process ID
    for (int k = 0; k < 3; k++) begin
      cmd        = ins_cmds[k];
      cmd.insert = 1'b0;
      if (k == 2) begin
        cmd.hpid = ~cmd.hpid;
      end
      send_update(cmd);
    end
    idle_cycles(3);
    for (int k = 0; k < 4; k++) begin
      lookup_mapping(ins_cmds[k], ins_cmds[k].pid, 1'b0);
    end
    end_lookups();
    finish_test(3, "removes");

    for (int k = 0; k < 5; k++) begin
      build_cmd(1'b1, FULL_SET, tlb_tag_t'(32'h3c00 + k), 6'h11, hpid_t'($random(seed)),
                set_cmds[k]);
    end
    for (int k = 0; k < 4; k++) begin
      send_update(set_cmds[k]);
    end
    idle_cycles(3);
    // Way 0 read, way 1 written, way 3 read, way 2 left alone
    lookup_mapping(set_cmds[0], 6'h11, 1'b0);
    lookup_mapping(set_cmds[1], 6'h11, 1'b1);
    lookup_mapping(set_cmds[3], 6'h11, 1'b0);
    end_lookups();
    send_update(set_cmds[4]);
    idle_cycles(3);
    for (int k = 0; k < 5; k++) begin
      lookup_mapping(set_cmds[k], 6'h11, 1'b0);
    end
    end_lookups();
    finish_test(4, $sformatf("replacement in a full set, way %0d", last_victim));

    // Small pools of sets, tags and IDs keep the hit rate up
    for (int r = 0; r < MIX_ROUNDS; r++) begin
      for (int u = 0; u < MIX_UPDATES; u++) begin
        g_idx = tlb_idx_t'(rand_below(8));
        g_tag = tlb_tag_t'(32'h2000 + rand_below(6));
        g_pid = pid_t'(1 + rand_below(2));
        g_way = find_way(g_idx, g_tag, g_pid);
        if (g_way >= 0) begin
          // A duplicate insert turns into a remove of the live mapping
          build_cmd(1'b0, g_idx, g_tag, g_pid, m_entry[g_idx][g_way].hpid, cmd);
        end else begin
          build_cmd(rand_below(4) != 0, g_idx, g_tag, g_pid,
                    hpid_t'(32'h5a00 + rand_below(2)), cmd);
        end
        send_update(cmd);
      end
      idle_cycles(3);
      for (int l = 0; l < MIX_LOOKUPS; l++) begin
        va = {tlb_tag_t'(32'h2000 + rand_below(6)), tlb_idx_t'(rand_below(8)),
              12'($random(seed))};
        issue_lookup(va, pid_t'(1 + rand_below(2)), 1'($random(seed)));
      end
      end_lookups();
    end
    finish_test(5, "mixed update and lookup phases");

    $display("checks passed: %0d, errors: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- logic/tlb_top.sv
`timescale 1ns/1ps

module tlb_top import tlb_pkg::*; (
  input  logic         aclk,
  input  logic         aresetn,
  input  logic         upd_valid,
  input  tlb_upd_t     upd_cmd,
  output logic         upd_ready,
  input  logic         lup_valid,
  input  tlb_lup_req_t lup_req,
  output logic         rsp_valid,
  output tlb_lup_rsp_t rsp
);

  // Update side
  tlb_idx_t          upd_idx;
  tlb_entry_t        way_rd_entry [N_WAYS];
  way_usage_t        way_rd_usage [N_WAYS];
  logic [N_WAYS-1:0] way_rd_valid;
  logic [N_WAYS-1:0] wr_en;
  tlb_entry_t        wr_entry;
  way_t              victim_way;
  logic              set_full;

  // Lookup side
  tlb_idx_t          lup_idx;
  tlb_entry_t        way_lup_entry [N_WAYS];
  logic [N_WAYS-1:0] touch;
  tlb_idx_t          touch_idx;
  logic              touch_wr;

  tlb_update_seq tlb_update_seq_inst (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .upd_valid  (upd_valid),
    .upd_cmd    (upd_cmd),
    .upd_ready  (upd_ready),
    .upd_idx    (upd_idx),
    .rd_entry   (way_rd_entry),
    .victim_way (victim_way),
    .set_full   (set_full),
    .wr_en      (wr_en),
    .wr_entry   (wr_entry)
  );

  for (genvar i = 0; i < N_WAYS; i++) begin : g_way
    tlb_way tlb_way_inst (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .upd_idx   (upd_idx),
      .wr_en     (wr_en[i]),
      .wr_entry  (wr_entry),
      .rd_entry  (way_rd_entry[i]),
      .rd_usage  (way_rd_usage[i]),
      .lup_idx   (lup_idx),
      .lup_entry (way_lup_entry[i]),
      .touch     (touch[i]),
      .touch_idx (touch_idx),
      .touch_wr  (touch_wr)
    );

    assign way_rd_valid[i] = way_rd_entry[i].valid;
  end

  tlb_victim_sel tlb_victim_sel_inst (
    .rd_valid   (way_rd_valid),
    .rd_usage   (way_rd_usage),
    .victim_way (victim_way),
    .set_full   (set_full)
  );

  tlb_lookup tlb_lookup_inst (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .lup_valid (lup_valid),
    .lup_req   (lup_req),
    .lup_idx   (lup_idx),
    .lup_entry (way_lup_entry),
    .touch     (touch),
    .touch_idx (touch_idx),
    .touch_wr  (touch_wr),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

//--- logic/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup import tlb_pkg::*; (
  input  logic              aclk,
  input  logic              aresetn,
  input  logic              lup_valid,
  input  tlb_lup_req_t      lup_req,
  output tlb_idx_t          lup_idx,
  input  tlb_entry_t        lup_entry [N_WAYS],
  output logic [N_WAYS-1:0] touch,
  output tlb_idx_t          touch_idx,
  output logic              touch_wr,
  output logic              rsp_valid,
  output tlb_lup_rsp_t      rsp
);

  // Stage 0 holds the request while the ways are read
  tlb_lup_req_t      req_q;
  logic              req_vld;
  // Stage 1 lines up with the way outputs
  tlb_idx_t          s1_idx;
  tlb_tag_t          s1_tag;
  pid_t              s1_pid;
  logic              s1_wr;
  logic              s1_vld;
  logic [N_WAYS-1:0] way_hit;
  logic              hit;
  way_t              hit_way;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      req_vld   <= 1'b0;
      s1_vld    <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      req_vld   <= lup_valid;
      s1_vld    <= req_vld;
      rsp_valid <= s1_vld;
    end
  end

  always_ff @(posedge aclk) begin
    req_q  <= lup_req;
    s1_idx <= req_q.vaddr[PG_BITS +: TLB_ORDER];
    s1_tag <= req_q.vaddr[PG_BITS + TLB_ORDER +: TAG_BITS];
    s1_pid <= req_q.pid;
    s1_wr  <= req_q.wr;
  end

  assign lup_idx = req_q.vaddr[PG_BITS +: TLB_ORDER];

  // --------------------
  // Tag compare
  // --------------------
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int i = 0; i < N_WAYS; i++) begin
      way_hit[i] = lup_entry[i].valid && (lup_entry[i].tag == s1_tag) &&
                   (lup_entry[i].pid == s1_pid);
      if (way_hit[i]) begin
        hit     = 1'b1;
        hit_way = way_t'(i);
      end
    end
  end

  // Usage update lands with the result register
  always_comb begin
    touch          = '0;
    touch[hit_way] = s1_vld && hit;
  end

  assign touch_idx = s1_idx;
  assign touch_wr  = s1_wr;

  always_ff @(posedge aclk) begin
    rsp.hit   <= hit;
    rsp.entry <= hit ? lup_entry[hit_way] : '0;
  end

endmodule

//--- logic/tlb_update_seq.sv
`timescale 1ns/1ps

module tlb_update_seq import tlb_pkg::*; (
  input  logic              aclk,
  input  logic              aresetn,
  input  logic              upd_valid,
  input  tlb_upd_t          upd_cmd,
  output logic              upd_ready,
  output tlb_idx_t          upd_idx,
  input  tlb_entry_t        rd_entry [N_WAYS],
  input  way_t              victim_way,
  input  logic              set_full,
  output logic [N_WAYS-1:0] wr_en,
  output tlb_entry_t        wr_entry
);

  upd_state_t        state;
  tlb_upd_t          cmd_q;
  logic [N_WAYS-1:0] ins_mask;
  logic [N_WAYS-1:0] rmv_match;

  // --------------------
  // Command FSM
  // --------------------
  assign upd_ready = (state == IDLE);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (upd_valid) begin
            state <= READ;
          end
        end
        // Ways register the set during this cycle
        READ: begin
          state <= COMMIT;
        end
        COMMIT: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Held for the whole read-compare-write
  always_ff @(posedge aclk) begin
    if (upd_ready && upd_valid) begin
      cmd_q <= upd_cmd;
    end
  end

  assign upd_idx = cmd_q.vpn.idx;

  // --------------------
  // Compare on the read set
  // --------------------
  always_comb begin
    ins_mask = '0;
    // Insert lands in the way picked by the victim selector
    ins_mask[victim_way] = 1'b1;
  end

  always_comb begin
    for (int i = 0; i < N_WAYS; i++) begin
      rmv_match[i] = (rd_entry[i].tag == cmd_q.vpn.tag) &&
                     (rd_entry[i].hpid == cmd_q.hpid);
    end
  end

  // --------------------
  // Write back
  // --------------------
  always_comb begin
    wr_entry.valid = cmd_q.insert;
    wr_entry.pid   = cmd_q.pid;
    wr_entry.tag   = cmd_q.vpn.tag;
    wr_entry.ppn   = cmd_q.ppn;
    wr_entry.hpid  = cmd_q.hpid;
  end

  always_comb begin
    wr_en = '0;
    if (state == COMMIT) begin
      // Remove writes an invalid entry into every matching way
      wr_en = cmd_q.insert ? ins_mask : rmv_match;
    end
  end

endmodule

//--- logic/tlb_victim_sel.sv
`timescale 1ns/1ps

module tlb_victim_sel import tlb_pkg::*; (
  input  logic [N_WAYS-1:0] rd_valid,
  input  way_usage_t        rd_usage [N_WAYS],
  output way_t              victim_way,
  output logic              set_full
);

  way_t       free_way;
  way_t       nru_way;
  logic [1:0] cur_usage;
  logic [1:0] min_usage;

  // Lowest free way, scanned downwards so the last hit wins
  always_comb begin
    set_full = 1'b1;
    free_way = '0;
    for (int i = N_WAYS - 1; i >= 0; i--) begin
      if (!rd_valid[i]) begin
        set_full = 1'b0;
        free_way = way_t'(i);
      end
    end
  end

  // Least used way, ties go to the higher number
  always_comb begin
    nru_way   = '0;
    min_usage = 2'b11;
    cur_usage = '0;
    for (int i = 0; i < N_WAYS; i++) begin
      cur_usage = rd_usage[i];
      if (cur_usage <= min_usage) begin
        min_usage = cur_usage;
        nru_way   = way_t'(i);
      end
    end
  end

  assign victim_way = set_full ? nru_way : free_way;

endmodule

//--- logic/tlb_way.sv
`timescale 1ns/1ps

module tlb_way import tlb_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,
  input  tlb_idx_t   upd_idx,
  input  logic       wr_en,
  input  tlb_entry_t wr_entry,
  output tlb_entry_t rd_entry,
  output way_usage_t rd_usage,
  input  tlb_idx_t   lup_idx,
  output tlb_entry_t lup_entry,
  input  logic       touch,
  input  tlb_idx_t   touch_idx,
  input  logic       touch_wr
);

  tlb_entry_t        mem [N_SETS];
  tlb_entry_t        upd_q;
  tlb_entry_t        lup_q;
  logic [N_SETS-1:0] valid_bits;
  logic [N_SETS-1:0] ref_bits;
  logic [N_SETS-1:0] mod_bits;
  logic              upd_vld_q;
  logic              lup_vld_q;

  // Payload store, both read ports registered
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[upd_idx] <= wr_entry;
    end
    upd_q <= mem[upd_idx];
    lup_q <= mem[lup_idx];
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      valid_bits <= '0;
      ref_bits   <= '0;
      mod_bits   <= '0;
      upd_vld_q  <= 1'b0;
      lup_vld_q  <= 1'b0;
      rd_usage   <= '0;
    end else begin
      if (touch) begin
        ref_bits[touch_idx] <= 1'b1;
        if (touch_wr) begin
          mod_bits[touch_idx] <= 1'b1;
        end
      end
      // New contents start unreferenced
      if (wr_en) begin
        valid_bits[upd_idx] <= wr_entry.valid;
        ref_bits[upd_idx]   <= 1'b0;
        mod_bits[upd_idx]   <= 1'b0;
      end
      upd_vld_q           <= valid_bits[upd_idx];
      lup_vld_q           <= valid_bits[lup_idx];
      rd_usage.referenced <= ref_bits[upd_idx];
      rd_usage.modified   <= mod_bits[upd_idx];
    end
  end

  always_comb begin
    rd_entry        = upd_q;
    rd_entry.valid  = upd_vld_q;
    lup_entry       = lup_q;
    lup_entry.valid = lup_vld_q;
  end

endmodule

//--- logic/tlb_pkg.sv
package tlb_pkg;

  // --------------------
  // Geometry
  // --------------------
  localparam int TLB_ORDER  = 6;
  localparam int N_SETS     = 2 ** TLB_ORDER;
  localparam int N_WAYS     = 4;
  localparam int WAY_BITS   = 2;

  // Address split for 4 KiB pages
  localparam int PG_BITS    = 12;
  localparam int VADDR_BITS = 48;
  localparam int PADDR_BITS = 40;
  localparam int TAG_BITS   = VADDR_BITS - TLB_ORDER - PG_BITS;
  localparam int PPN_BITS   = PADDR_BITS - PG_BITS;
  localparam int PID_BITS   = 6;
  localparam int HPID_BITS  = 32;

  typedef logic [VADDR_BITS-1:0] vaddr_t;
  typedef logic [TLB_ORDER-1:0]  tlb_idx_t;
  typedef logic [TAG_BITS-1:0]   tlb_tag_t;
  typedef logic [PPN_BITS-1:0]   ppn_t;
  typedef logic [PID_BITS-1:0]   pid_t;
  typedef logic [HPID_BITS-1:0]  hpid_t;
  typedef logic [WAY_BITS-1:0]   way_t;

  // --------------------
  // Packed records
  // --------------------
  typedef struct packed {
    logic     valid;
    pid_t     pid;
    tlb_tag_t tag;
    ppn_t     ppn;
    hpid_t    hpid;
  } tlb_entry_t;

  // Insert when set, remove when clear
  typedef struct packed {
    logic insert;
    pid_t pid;
    struct packed {
      tlb_tag_t tag;
      tlb_idx_t idx;
    } vpn;
    ppn_t  ppn;
    hpid_t hpid;
  } tlb_upd_t;

  typedef struct packed {
    vaddr_t vaddr;
    pid_t   pid;
    logic   wr;
  } tlb_lup_req_t;

  typedef struct packed {
    logic       hit;
    tlb_entry_t entry;
  } tlb_lup_rsp_t;

  // Compared as a 2-bit value, referenced bit weighs more
  typedef struct packed {
    logic referenced;
    logic modified;
  } way_usage_t;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    COMMIT
  } upd_state_t;

endpackage
